// ==== verilog/pp_pkg.sv ====
// --------------------
// path parser package
// shared widths, word types and the splitter state encoding
// --------------------

package pp_pkg;

   localparam int DATA_W = 64;                 // header word width
   localparam int PLEN_LSB = DATA_W - 8;       // path length byte sits in the top byte

   localparam int LEN_W = 5;                   // chunk length in words
   localparam int BUF_WORDS = 16;              // path buffer capacity
   localparam int CREDIT_W = 5;                // holds 0 to BUF_WORDS
   localparam int LEN_FIFO_DEPTH_W = 2;        // four chunks in flight

   typedef logic [DATA_W-1:0] pp_word_t;
   typedef logic [LEN_W-1:0] pp_len_t;
   typedef logic [CREDIT_W-1:0] pp_credit_t;

   // splitter FSM
   typedef enum logic [1:0] {
      ST_IDLE,                                 // waiting for a first word
      ST_PATH,                                 // path chunk words
      ST_INST,                                 // instruction chunk words
      ST_DROP                                  // swallow the rest of a dropped packet
   } split_state_t;

endpackage

// ==== verilog/pp_sync_fifo.sv ====
// --------------------
// small synchronous FIFO
// first-word-fall-through, head entry always on dout
// --------------------

`timescale 1ns/1ps

module pp_sync_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH_W = 2
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             wr,
   input  logic [WIDTH-1:0] din,
   input  logic             rd,
   output logic [WIDTH-1:0] dout,
   output logic             empty,
   output logic             full
);

   localparam int DEPTH = 1 << DEPTH_W;

   logic [WIDTH-1:0] mem [DEPTH];
   logic [DEPTH_W-1:0] wr_ptr;
   logic [DEPTH_W-1:0] rd_ptr;
   logic [DEPTH_W:0] count;
   logic do_wr;
   logic do_rd;

   assign do_wr = wr & ~full;                  // write to a full fifo is dropped
   assign do_rd = rd & ~empty;
   assign empty = (count == '0);
   assign full = (count == (DEPTH_W+1)'(DEPTH));
   assign dout = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         if (do_wr && !do_rd) count <= count + 1'b1;
         else if (do_rd && !do_wr) count <= count - 1'b1;
      end
   end

endmodule

// ==== verilog/pp_source_arb.sv ====
// --------------------
// header source arbiter
// whole-packet alternating grant between auth and local sources
// --------------------

`timescale 1ns/1ps

module pp_source_arb (
   input  logic             clk,
   input  logic             rst,
   input  logic             auth_valid,
   output logic             auth_ready,
   input  logic             auth_sop,
   input  logic             auth_eop,
   input  pp_pkg::pp_word_t auth_data,
   input  logic             auth_discard,
   input  logic             local_valid,
   output logic             local_ready,
   input  logic             local_sop,
   input  logic             local_eop,
   input  pp_pkg::pp_word_t local_data,
   output logic             arb_valid,
   input  logic             arb_ready,
   output logic             arb_sop,
   output logic             arb_eop,
   output pp_pkg::pp_word_t arb_data,
   output logic             arb_discard
);

   logic grant_auth;                           // 0 points to local
   logic in_pkt;
   logic auth_pick;
   logic local_pick;
   logic arb_xfer;

   // inside a packet the grant is locked, between packets the granted side has priority
   assign auth_pick = in_pkt ? grant_auth : (auth_valid & (grant_auth | ~local_valid));
   assign local_pick = in_pkt ? ~grant_auth : (local_valid & (~grant_auth | ~auth_valid));

   assign auth_ready = arb_ready & auth_pick;
   assign local_ready = arb_ready & local_pick;

   assign arb_valid = (auth_pick & auth_valid) | (local_pick & local_valid);
   assign arb_sop = auth_pick ? auth_sop : local_sop;
   assign arb_eop = auth_pick ? auth_eop : local_eop;
   assign arb_data = auth_pick ? auth_data : local_data;
   assign arb_discard = auth_pick & auth_discard;    // local packets never discard

   assign arb_xfer = arb_valid & arb_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         grant_auth <= 1'b0;
         in_pkt <= 1'b0;
      end else if (arb_xfer) begin
         if (arb_eop) begin
            in_pkt <= 1'b0;
            // hand over to the other side only if it is waiting
            grant_auth <= auth_pick ? ~local_valid : auth_valid;
         end else if (arb_sop) begin
            in_pkt <= 1'b1;
            grant_auth <= auth_pick;
         end
      end
   end

endmodule

// ==== verilog/pp_credit_tracker.sv ====
// --------------------
// path buffer credit tracker
// free-word count, chunk lengths queued until the buffer returns them
// --------------------

`timescale 1ns/1ps

module pp_credit_tracker (
   input  logic               clk,
   input  logic               rst,
   input  logic               take,
   input  pp_pkg::pp_len_t    take_len,
   input  logic               path_done,
   output pp_pkg::pp_credit_t credits
);

   import pp_pkg::*;

   pp_len_t head_len;
   logic len_empty;
   logic len_full;
   logic give;
   pp_credit_t take_amt;
   pp_credit_t give_amt;

   assign give = path_done & ~len_empty;       // stray path_done is ignored
   assign take_amt = take ? pp_credit_t'(take_len) : '0;
   assign give_amt = give ? pp_credit_t'(head_len) : '0;

   pp_sync_fifo #(
      .WIDTH   (LEN_W),
      .DEPTH_W (LEN_FIFO_DEPTH_W)
   ) len_fifo_inst (
      .clk   (clk),
      .rst   (rst),
      .wr    (take),
      .din   (take_len),
      .rd    (give),
      .dout  (head_len),
      .empty (len_empty),
      .full  (len_full)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         credits <= pp_credit_t'(BUF_WORDS);
      end else if (!(take && len_full)) begin
         credits <= credits - take_amt + give_amt;    // both apply in one cycle
      end else begin
         credits <= credits + give_amt;        // no slot to remember the length
      end
   end

endmodule

// ==== verilog/pp_chunk_splitter.sv ====
// --------------------
// path chunk splitter
// drop decision on the first word, path words then instruction words
// --------------------

`timescale 1ns/1ps

module pp_chunk_splitter (
   input  logic               clk,
   input  logic               rst,
   input  logic               arb_valid,
   output logic               arb_ready,
   input  logic               arb_sop,
   input  logic               arb_eop,
   input  pp_pkg::pp_word_t   arb_data,
   input  logic               arb_discard,
   output logic               path_valid,
   input  logic               path_ready,
   output logic               path_sop,
   output logic               path_eop,
   output pp_pkg::pp_word_t   path_data,
   output logic               inst_valid,
   input  logic               inst_ready,
   output logic               inst_sop,
   output logic               inst_eop,
   output pp_pkg::pp_word_t   inst_data,
   input  pp_pkg::pp_credit_t credits,
   output logic               take,
   output pp_pkg::pp_len_t    take_len
);

   import pp_pkg::*;

   split_state_t state;
   pp_len_t p_len;                             // latched path length
   pp_len_t word_cnt;                          // path words sent so far
   logic inst_first;
   logic [7:0] first_len;
   logic drop;
   logic path_free;
   logic inst_free;
   logic arb_xfer;
   logic first_xfer;
   logic path_load;
   logic inst_load;
   logic path_last;

   assign first_len = arb_data[DATA_W-1:PLEN_LSB];
   assign drop = arb_discard | (first_len > credits);
   assign take_len = first_len[LEN_W-1:0];

   // an output stage can take a word if empty or draining this cycle
   assign path_free = ~path_valid | path_ready;
   assign inst_free = ~inst_valid | inst_ready;

   always_comb begin
      case (state)
         ST_IDLE, ST_PATH: arb_ready = path_free;
         ST_INST:          arb_ready = inst_free;
         ST_DROP:          arb_ready = 1'b1;
         default:          arb_ready = 1'b0;
      endcase
   end

   assign arb_xfer = arb_valid & arb_ready;
   assign first_xfer = arb_xfer & arb_sop & (state == ST_IDLE);
   assign take = first_xfer & ~drop;
   assign path_load = take | (arb_xfer & (state == ST_PATH));
   assign inst_load = arb_xfer & (state == ST_INST);
   assign path_last = (state == ST_IDLE) ? (take_len == pp_len_t'(1))
                                         : ((word_cnt + 1'b1) == p_len);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
         word_cnt <= '0;
         inst_first <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: if (first_xfer) begin
               word_cnt <= pp_len_t'(1);
               if (drop) state <= arb_eop ? ST_IDLE : ST_DROP;
               else if (arb_eop) state <= ST_IDLE;
               else if (path_last) begin
                  state <= ST_INST;
                  inst_first <= 1'b1;
               end else state <= ST_PATH;
            end
            ST_PATH: if (arb_xfer) begin
               word_cnt <= word_cnt + 1'b1;
               if (arb_eop) state <= ST_IDLE;  // short packet ends the path chunk
               else if (path_last) begin
                  state <= ST_INST;
                  inst_first <= 1'b1;
               end
            end
            ST_INST: if (arb_xfer) begin
               inst_first <= 1'b0;
               if (arb_eop) state <= ST_IDLE;
            end
            ST_DROP: if (arb_xfer && arb_eop) state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         path_valid <= 1'b0;
         inst_valid <= 1'b0;
      end else begin
         if (path_load) path_valid <= 1'b1;
         else if (path_ready) path_valid <= 1'b0;
         if (inst_load) inst_valid <= 1'b1;
         else if (inst_ready) inst_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (first_xfer) p_len <= take_len;
      if (path_load) begin
         path_data <= arb_data;
         path_sop <= (state == ST_IDLE);
         path_eop <= path_last | arb_eop;
      end
      if (inst_load) begin
         inst_data <= arb_data;
         inst_sop <= inst_first;
         inst_eop <= arb_eop;
      end
   end

endmodule

// ==== verilog/pp_front_end.sv ====
// --------------------
// path parser front end
// arbiter, chunk splitter and path buffer credits
// --------------------

`timescale 1ns/1ps

module pp_front_end (
   input  logic               clk,
   input  logic               rst,
   input  logic               auth_valid,
   output logic               auth_ready,
   input  logic               auth_sop,
   input  logic               auth_eop,
   input  pp_pkg::pp_word_t   auth_data,
   input  logic               auth_discard,
   input  logic               local_valid,
   output logic               local_ready,
   input  logic               local_sop,
   input  logic               local_eop,
   input  pp_pkg::pp_word_t   local_data,
   output logic               path_valid,
   input  logic               path_ready,
   output logic               path_sop,
   output logic               path_eop,
   output pp_pkg::pp_word_t   path_data,
   output logic               inst_valid,
   input  logic               inst_ready,
   output logic               inst_sop,
   output logic               inst_eop,
   output pp_pkg::pp_word_t   inst_data,
   input  logic               path_done,
   output pp_pkg::pp_credit_t path_credits
);

   import pp_pkg::*;

   logic arb_valid;
   logic arb_ready;
   logic arb_sop;
   logic arb_eop;
   pp_word_t arb_data;
   logic arb_discard;
   logic take;
   pp_len_t take_len;

   pp_source_arb arb_inst (
      .clk          (clk),
      .rst          (rst),
      .auth_valid   (auth_valid),
      .auth_ready   (auth_ready),
      .auth_sop     (auth_sop),
      .auth_eop     (auth_eop),
      .auth_data    (auth_data),
      .auth_discard (auth_discard),
      .local_valid  (local_valid),
      .local_ready  (local_ready),
      .local_sop    (local_sop),
      .local_eop    (local_eop),
      .local_data   (local_data),
      .arb_valid    (arb_valid),
      .arb_ready    (arb_ready),
      .arb_sop      (arb_sop),
      .arb_eop      (arb_eop),
      .arb_data     (arb_data),
      .arb_discard  (arb_discard)
   );

   pp_chunk_splitter splitter_inst (
      .clk         (clk),
      .rst         (rst),
      .arb_valid   (arb_valid),
      .arb_ready   (arb_ready),
      .arb_sop     (arb_sop),
      .arb_eop     (arb_eop),
      .arb_data    (arb_data),
      .arb_discard (arb_discard),
      .path_valid  (path_valid),
      .path_ready  (path_ready),
      .path_sop    (path_sop),
      .path_eop    (path_eop),
      .path_data   (path_data),
      .inst_valid  (inst_valid),
      .inst_ready  (inst_ready),
      .inst_sop    (inst_sop),
      .inst_eop    (inst_eop),
      .inst_data   (inst_data),
      .credits     (path_credits),
      .take        (take),
      .take_len    (take_len)
   );

   pp_credit_tracker tracker_inst (
      .clk       (clk),
      .rst       (rst),
      .take      (take),
      .take_len  (take_len),
      .path_done (path_done),
      .credits   (path_credits)
   );

endmodule

// ==== dv/pp_checker.sv ====
// --------------------
// front end scoreboard
// predicts drops, output words and credits from the packet table
// --------------------

`timescale 1ns/1ps

module pp_checker #(
   parameter int NUM_PKTS = 1
) (
   input  logic               clk,
   input  logic               rst,
   input  int                 tbl_id [NUM_PKTS],
   input  int                 tbl_len [NUM_PKTS],
   input  int                 tbl_p [NUM_PKTS],
   input  int                 tbl_disc [NUM_PKTS],
   input  int                 tbl_drop [NUM_PKTS],
   input  logic               auth_valid,
   input  logic               auth_ready,
   input  pp_pkg::pp_word_t   auth_data,
   input  logic               local_valid,
   input  logic               local_ready,
   input  pp_pkg::pp_word_t   local_data,
   input  logic               path_valid,
   input  logic               path_ready,
   input  logic               path_sop,
   input  logic               path_eop,
   input  pp_pkg::pp_word_t   path_data,
   input  logic               inst_valid,
   input  logic               inst_ready,
   input  logic               inst_sop,
   input  logic               inst_eop,
   input  pp_pkg::pp_word_t   inst_data,
   input  logic               path_done,
   input  pp_pkg::pp_credit_t path_credits,
   input  logic               end_check,
   output int                 errors
);

   import pp_pkg::*;

   localparam int MAX_LEN = 8;

   pp_word_t sent [NUM_PKTS][MAX_LEN];         // source words per table entry
   int in_cnt [NUM_PKTS];
   int out_cnt [2][NUM_PKTS];                  // 0 path, 1 inst
   int cur [2];                                // entry whose chunk is on each output
   logic dropped [NUM_PKTS];
   int model_cr;
   int len_q [$];                              // accepted path lengths, oldest first
   logic checked;

   function automatic int entry_of(input pp_word_t w);
      for (int e = 0; e < NUM_PKTS; e++) begin
         if (tbl_id[e] == int'(w[55:48])) return e;
      end
      return -1;
   endfunction

   task automatic check_value(input string name, input int e, input pp_word_t got,
                              input pp_word_t exp);
      if (got !== exp) begin
         $display("error %0t %s of packet %0d: got %0h expected %0h", $time, name,
                  tbl_id[e], got, exp);
         errors++;
      end
   endtask

   // a packet's fate is settled when its first word leaves the source
   task automatic take_word(input pp_word_t w);
      int e;
      e = entry_of(w);
      if (e < 0 || in_cnt[e] >= tbl_len[e]) begin
         $display("source sent a word that the table does not hold, id %0d", w[55:48]);
         errors++;
         return;
      end
      if (in_cnt[e] == 0) begin
         dropped[e] = (tbl_disc[e] != 0) || (tbl_p[e] > model_cr);
         if (dropped[e] != (tbl_drop[e] != 0)) begin
            $display("packet %0d drop prediction disagrees with the table", tbl_id[e]);
            errors++;
         end
         if (!dropped[e]) begin
            model_cr -= tbl_p[e];
            len_q.push_back(tbl_p[e]);
         end
      end
      sent[e][in_cnt[e]] = w;
      in_cnt[e]++;
   endtask

   task automatic check_out(input int s, input pp_word_t data, input logic sop,
                            input logic eop);
      int e;
      int k;
      int first;
      int last;
      string side;
      e = entry_of(data);
      side = (s == 1) ? "inst" : "path";
      if (e < 0) begin
         $display("%s output carries unknown packet id %0d", side, data[55:48]);
         errors++;
         return;
      end
      k = out_cnt[s][e];
      first = (s == 1) ? tbl_p[e] : 0;
      last = (s == 1) ? tbl_len[e] - 1 : tbl_p[e] - 1;
      if (k > 0 && e != cur[s]) begin
         $display("%s chunk of packet %0d interleaved with packet %0d", side,
                  tbl_id[cur[s]], tbl_id[e]);
         errors++;
      end
      cur[s] = e;
      out_cnt[s][e]++;
      if (dropped[e] || first + k > last || first + k >= in_cnt[e]) begin
         $display("%s output word %0d of packet %0d was not expected", side, k, tbl_id[e]);
         errors++;
      end else begin
         check_value({side, "_data"}, e, data, sent[e][first + k]);
         check_value({side, "_sop"}, e, pp_word_t'(sop), pp_word_t'(k == 0));
         check_value({side, "_eop"}, e, pp_word_t'(eop), pp_word_t'(first + k == last));
      end
   endtask

   task automatic final_check();
      int want_path;
      int want_inst;
      for (int e = 0; e < NUM_PKTS; e++) begin
         want_path = dropped[e] ? 0 : tbl_p[e];
         want_inst = dropped[e] ? 0 : tbl_len[e] - tbl_p[e];
         if (in_cnt[e] != tbl_len[e] || out_cnt[0][e] != want_path ||
             out_cnt[1][e] != want_inst) begin
            $display("packet %0d incomplete: %0d words in, %0d path and %0d inst words out",
                     tbl_id[e], in_cnt[e], out_cnt[0][e], out_cnt[1][e]);
            errors++;
         end
      end
   endtask

   // negedge sampling, every handshake seen here completes on the next rising edge
   always @(negedge clk) begin
      int give;
      if (rst) begin
         errors = 0;
         model_cr = BUF_WORDS;
         len_q.delete();
         checked = 1'b0;
         cur = '{0, 0};
         for (int e = 0; e < NUM_PKTS; e++) begin
            in_cnt[e] = 0;
            out_cnt[0][e] = 0;
            out_cnt[1][e] = 0;
            dropped[e] = 1'b0;
         end
      end else begin
         if (int'(path_credits) != model_cr) begin
            $display("error %0t path_credits: got %0d expected %0d", $time,
                     path_credits, model_cr);
            errors++;
         end
         give = 0;
         if (path_done && len_q.size() > 0) give = len_q.pop_front();
         if (auth_valid && auth_ready) take_word(auth_data);
         if (local_valid && local_ready) take_word(local_data);
         model_cr += give;                     // take and return both land together
         if (path_valid && path_ready) check_out(0, path_data, path_sop, path_eop);
         if (inst_valid && inst_ready) check_out(1, inst_data, inst_sop, inst_eop);
         if (end_check && !checked) begin
            checked = 1'b1;
            final_check();
         end
      end
   end

endmodule

// ==== dv/tb_pp_front_end.sv ====
// --------------------
// path parser front end testbench
// packet table on both sources, random output stalls, path_done returns
// --------------------

`timescale 1ns/1ps

module tb_pp_front_end;

   import pp_pkg::*;

   localparam int NUM_PKTS = 15;
   localparam int MAX_CYCLES = 40 * NUM_PKTS + 200;

   // one packet per position; src 1 is auth, same 1 starts the next entry alongside
   // drop is the expected fate, done counts path_done pulses after the entry drains
   int t_src [NUM_PKTS]  = '{0, 1, 0, 1, 0, 1, 0, 1, 1, 0, 1, 0, 1, 0, 1};
   int t_len [NUM_PKTS]  = '{4, 3, 3, 4, 6, 5, 4, 3, 2, 5, 5, 4, 3, 6, 7};
   int t_p [NUM_PKTS]    = '{2, 1, 3, 2, 6, 5, 4, 2, 1, 3, 2, 1, 2, 4, 3};
   int t_disc [NUM_PKTS] = '{0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
   int t_id [NUM_PKTS]   = '{16, 17, 18, 19, 20, 21, 22, 23, 24, 25, 26, 27, 28, 29, 30};
   int t_same [NUM_PKTS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 1, 0, 0};
   int t_done [NUM_PKTS] = '{0, 0, 0, 3, 0, 0, 0, 0, 4, 1, 0, 2, 0, 2, 1};
   int t_drop [NUM_PKTS] = '{0, 0, 0, 1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0};

   logic clk = 1'b0;
   logic rst = 1'b1;
   logic auth_valid = 1'b0;
   logic auth_sop = 1'b0;
   logic auth_eop = 1'b0;
   pp_word_t auth_data = '0;
   logic auth_discard = 1'b0;
   logic local_valid = 1'b0;
   logic local_sop = 1'b0;
   logic local_eop = 1'b0;
   pp_word_t local_data = '0;
   logic path_ready = 1'b0;
   logic inst_ready = 1'b0;
   logic path_done = 1'b0;
   logic end_check = 1'b0;
   logic auth_ready;
   logic local_ready;
   logic path_valid;
   logic path_sop;
   logic path_eop;
   pp_word_t path_data;
   logic inst_valid;
   logic inst_sop;
   logic inst_eop;
   pp_word_t inst_data;
   pp_credit_t path_credits;
   int errors;
   int seed = 32'h75c11cc3;
   int cycles = 0;
   int i;
   int last;

   pp_front_end pp_front_end_inst (
      .clk (clk), .rst (rst),
      .auth_valid (auth_valid), .auth_ready (auth_ready), .auth_sop (auth_sop),
      .auth_eop (auth_eop), .auth_data (auth_data), .auth_discard (auth_discard),
      .local_valid (local_valid), .local_ready (local_ready), .local_sop (local_sop),
      .local_eop (local_eop), .local_data (local_data),
      .path_valid (path_valid), .path_ready (path_ready), .path_sop (path_sop),
      .path_eop (path_eop), .path_data (path_data),
      .inst_valid (inst_valid), .inst_ready (inst_ready), .inst_sop (inst_sop),
      .inst_eop (inst_eop), .inst_data (inst_data),
      .path_done (path_done), .path_credits (path_credits)
   );

   pp_checker #(.NUM_PKTS (NUM_PKTS)) checker_inst (
      .clk (clk), .rst (rst),
      .tbl_id (t_id), .tbl_len (t_len), .tbl_p (t_p), .tbl_disc (t_disc), .tbl_drop (t_drop),
      .auth_valid (auth_valid), .auth_ready (auth_ready), .auth_data (auth_data),
      .local_valid (local_valid), .local_ready (local_ready), .local_data (local_data),
      .path_valid (path_valid), .path_ready (path_ready), .path_sop (path_sop),
      .path_eop (path_eop), .path_data (path_data),
      .inst_valid (inst_valid), .inst_ready (inst_ready), .inst_sop (inst_sop),
      .inst_eop (inst_eop), .inst_data (inst_data),
      .path_done (path_done), .path_credits (path_credits),
      .end_check (end_check), .errors (errors)
   );

   always #50 clk = ~clk;

   // each output stalls about one cycle in four
   always @(posedge clk) begin
      path_ready <= ($random(seed) & 3) != 0;
      inst_ready <= ($random(seed) & 3) != 0;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Testbench failed");
         $finish;
      end
   end

   // starts and ends on a rising edge
   task automatic send_pkt(input int n);
      pp_word_t w;
      logic ok;
      for (int k = 0; k < t_len[n]; k++) begin
         w = {$random(seed), $random(seed)};
         w[55:48] = t_id[n][7:0];
         if (k == 0) w[63:56] = t_p[n][7:0];
         if (t_src[n] == 1) begin
            auth_valid <= 1'b1;
            auth_sop <= (k == 0);
            auth_eop <= (k == t_len[n] - 1);
            auth_data <= w;
            auth_discard <= (t_disc[n] != 0);
         end else begin
            local_valid <= 1'b1;
            local_sop <= (k == 0);
            local_eop <= (k == t_len[n] - 1);
            local_data <= w;
         end
         do begin
            @(negedge clk);
            ok = (t_src[n] == 1) ? auth_ready : local_ready;
            @(posedge clk);
         end while (!ok);
      end
      if (t_src[n] == 1) auth_valid <= 1'b0;
      else local_valid <= 1'b0;
   endtask

   task automatic wait_idle();
      do begin
         @(negedge clk);
      end while (path_valid || inst_valid);
      @(posedge clk);
   endtask

   task automatic return_chunks(input int count);
      for (int k = 0; k < count; k++) begin
         path_done <= 1'b1;
         @(posedge clk);
         path_done <= 1'b0;
         @(posedge clk);
      end
   endtask

   initial begin
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      i = 0;
      while (i < NUM_PKTS) begin
         if (t_same[i] != 0 && i + 1 < NUM_PKTS) begin
            fork
               send_pkt(i);
               send_pkt(i + 1);
            join
            last = i + 1;
         end else begin
            send_pkt(i);
            last = i;
         end
         i = last + 1;
         wait_idle();
         return_chunks(t_done[last]);
      end
      end_check <= 1'b1;
      repeat (2) @(posedge clk);
      $display("%0d errors over %0d packets", errors, NUM_PKTS);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
verilog/pp_pkg.sv
verilog/pp_sync_fifo.sv
verilog/pp_source_arb.sv
verilog/pp_credit_tracker.sv
verilog/pp_chunk_splitter.sv
verilog/pp_front_end.sv
dv/pp_checker.sv
dv/tb_pp_front_end.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the front end testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_pp_front_end

out=$(./obj_dir/Vtb_pp_front_end)
echo "$out"

if echo "$out" | grep -q "^Testbench passed$"; then
   exit 0
fi
exit 1
